/* fma_unit.f */
+incdir+include
hdl/fma_pkg.sv
hdl/fma_pipe_stage.sv
hdl/fma_operand_prep.sv
hdl/fma_mant_datapath.sv
hdl/fma_normalize.sv
hdl/fma_round.sv
hdl/fma_top.sv
bench/fma_clock_gen.sv
bench/fma_tb.sv

/* bench/fma_tb.sv */
// Directed tests for fma_top. Expected values assume exact binary32 operands and normal results
module fma_tb;
  import fma_pkg::*;

  // 51 operations at 3 cycles each plus the stalls of the back-pressure stream, margin of four
  localparam int MAX_CYCLES = 2000;

  localparam status_t  NO_FLAGS   = 4'b0000;
  localparam status_t  NV_ONLY    = 4'b1000;
  localparam status_t  NX_ONLY    = 4'b0001;
  localparam status_t  OF_NX      = 4'b0101;
  localparam fp_word_t QNAN       = 32'h7fc00000;
  localparam fp_word_t POS_INF    = 32'h7f800000;
  localparam fp_word_t NEG_INF    = 32'hff800000;
  localparam fp_word_t ONE        = 32'h3f800000;
  localparam fp_word_t MAX_NORMAL = 32'h7f7fffff;

  logic      clk;
  logic      arst_n;
  logic      in_valid_i;
  logic      in_ready_o;
  fma_req_t  in_req_i;
  logic      out_valid_o;
  logic      out_ready_i;
  fma_resp_t out_resp_o;
  logic      busy_o;

  // Requests and expected responses of the current test, in order
  fma_req_t  req_q[$];
  fp_word_t  exp_word_q[$];
  status_t   exp_status_q[$];
  fma_resp_t recv_q[$];

  int seed = 32'h877f94c1;
  int cycle_count = 0;
  int tests_run = 0;
  int checks = 0;
  int errors = 0;

  fma_clock_gen u_clock_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  fma_top uut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_req_i    (in_req_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_resp_o  (out_resp_o),
    .busy_o      (busy_o)
  );

  // --------------------------------------------------
  // Timeout
  // --------------------------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) begin
      $display("Run timed out after %0d cycles without finishing the tests", cycle_count);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Reference helpers and compare tasks
  // --------------------------------------------------
  // Exact double to binary32, normal values and zeros only
  function automatic fp_word_t to_single(input real value);
    logic [63:0] bits;
    logic [10:0] exp_d;
    bits  = $realtobits(value);
    exp_d = bits[62:52];
    if (exp_d == '0) begin
      return {bits[63], 31'b0};
    end
    return {bits[63], 8'(exp_d - 11'd896), bits[51:29]};
  endfunction

  // FMADD family by the operation table, mod negates the addend
  function automatic real fused_value(input real a, input real b, input real c,
                                      input operation_e op, input logic mod);
    real prod;
    real addend;
    prod   = a * b;
    addend = mod ? -c : c;
    if (op == FNMSUB) begin
      prod = -prod;
    end
    return prod + addend;
  endfunction

  // Whether the magnitude of 1 + fraction rounds up, the even neighbour is 1.0
  function automatic logic rounds_away(input roundmode_e mode, input logic neg, input logic tie);
    case (mode)
      RNE:     return !tie;
      RTZ:     return 1'b0;
      RDN:     return neg;
      RUP:     return !neg;
      default: return 1'b1;
    endcase
  endfunction

  task automatic check_word(input string name, input fp_word_t expected, input fp_word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s result: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_status(input string name, input status_t expected, input status_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s flags: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("Error: %s", msg);
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic clear_ops();
    req_q.delete();
    exp_word_q.delete();
    exp_status_q.delete();
  endtask

  task automatic queue_op(input fp_word_t a, input fp_word_t b, input fp_word_t c,
                          input operation_e op, input logic mod, input roundmode_e rm,
                          input fp_word_t exp_word, input status_t exp_status);
    fma_req_t req;
    req.operand_a = a;
    req.operand_b = b;
    req.operand_c = c;
    req.rnd_mode  = rm;
    req.op        = op;
    req.op_mod    = mod;
    req_q.push_back(req);
    exp_word_q.push_back(exp_word);
    exp_status_q.push_back(exp_status);
  endtask

  task automatic queue_fused(input real a, input real b, input real c,
                             input operation_e op, input logic mod);
    queue_op(to_single(a), to_single(b), to_single(c), op, mod, RNE,
             to_single(fused_value(a, b, c, op, mod)), NO_FLAGS);
  endtask

  // Streams the queued requests, collects results in order and compares them
  task automatic run_batch(input string name, input bit stall, input bit check_latency);
    int   sent;
    int   got;
    int   edge_idx;
    int   accept_edge[$];
    logic accept;
    logic take;
    fma_resp_t resp;
    sent     = 0;
    got      = 0;
    edge_idx = 0;
    recv_q.delete();
    while (got < req_q.size()) begin
      @(negedge clk);
      out_ready_i = stall ? 1'($random(seed)) : 1'b1;
      in_valid_i  = (sent < req_q.size());
      if (sent < req_q.size()) begin
        in_req_i = req_q[sent];
      end
      // Let the combinational ready path settle
      #1;
      accept = in_valid_i && in_ready_o;
      take   = out_valid_o && out_ready_i;
      resp   = out_resp_o;
      @(posedge clk);
      edge_idx++;
      if (accept) begin
        accept_edge.push_back(edge_idx);
        sent++;
      end
      if (take) begin
        // Valid shows two edges after acceptance, the transfer happens on the third
        if (check_latency && (edge_idx - accept_edge[got] != 3)) begin
          errors++;
          $display("FAILED %s[%0d] latency: expected 3, actual %0d", name, got,
                   edge_idx - accept_edge[got]);
        end
        recv_q.push_back(resp);
        got++;
      end
    end
    @(negedge clk);
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    for (int i = 0; i < recv_q.size(); i++) begin
      check_word($sformatf("%s[%0d]", name, i), exp_word_q[i], recv_q[i].result);
      check_status($sformatf("%s[%0d]", name, i), exp_status_q[i], recv_q[i].status);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    $display("Test %s finished with %0d errors", name, errors - errors_before);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic fused_ops();
    int errors_before;
    errors_before = errors;
    @(negedge clk);
    if (out_valid_o || busy_o || !in_ready_o) begin
      report_error("pipeline not idle and ready after reset");
    end
    clear_ops();
    queue_fused(3.0, 5.0, 2.0, FMADD, 1'b0);
    queue_fused(3.0, 5.0, 2.0, FMADD, 1'b1);
    queue_fused(2.0, 7.0, 20.0, FNMSUB, 1'b0);
    queue_fused(4.0, 2.5, 1.0, FNMSUB, 1'b1);
    run_batch("fused", 1'b0, 1'b1);
    end_test("fused", errors_before);
  endtask

  task automatic add_sub_mul();
    int errors_before;
    errors_before = errors;
    clear_ops();
    // Operand A of ADD and operand C of MUL are junk that must be ignored
    queue_op(to_single(9.0), to_single(6.0), to_single(1.5), ADD, 1'b0, RNE,
             to_single(7.5), NO_FLAGS);
    queue_op(to_single(9.0), to_single(6.0), to_single(1.5), ADD, 1'b1, RNE,
             to_single(4.5), NO_FLAGS);
    queue_op(to_single(6.0), to_single(-2.5), to_single(100.0), MUL, 1'b0, RNE,
             to_single(-15.0), NO_FLAGS);
    // Signed zeros
    queue_op(to_single(5.0), 32'h00000000, ONE, MUL, 1'b0, RNE, 32'h00000000, NO_FLAGS);
    queue_op(to_single(-5.0), 32'h00000000, ONE, MUL, 1'b0, RNE, 32'h80000000, NO_FLAGS);
    queue_op(ONE, to_single(3.0), to_single(-3.0), ADD, 1'b0, RDN, 32'h80000000, NO_FLAGS);
    queue_op(ONE, to_single(3.0), to_single(-3.0), ADD, 1'b0, RNE, 32'h00000000, NO_FLAGS);
    run_batch("add_sub_mul", 1'b0, 1'b0);
    end_test("add_sub_mul", errors_before);
  endtask

  task automatic special_cases();
    int errors_before;
    errors_before = errors;
    clear_ops();
    queue_op(POS_INF, 32'h00000000, QNAN, FMADD, 1'b0, RNE, QNAN, NV_ONLY);
    queue_op(32'h7f800001, ONE, ONE, FMADD, 1'b0, RNE, QNAN, NV_ONLY);
    queue_op(ONE, QNAN, ONE, FMADD, 1'b0, RNE, QNAN, NO_FLAGS);
    // inf - inf through the modifier
    queue_op(POS_INF, ONE, POS_INF, FMADD, 1'b1, RNE, QNAN, NV_ONLY);
    queue_op(NEG_INF, to_single(2.0), ONE, FMADD, 1'b0, RNE, NEG_INF, NO_FLAGS);
    queue_op(ONE, to_single(2.0), POS_INF, FMADD, 1'b0, RNE, POS_INF, NO_FLAGS);
    run_batch("specials", 1'b0, 1'b0);
    end_test("specials", errors_before);
  endtask

  task automatic rounding_modes();
    int         errors_before;
    roundmode_e modes[5];
    fp_word_t   fraction;
    logic       tie;
    logic       neg;
    errors_before = errors;
    modes = '{RNE, RTZ, RDN, RUP, RMM};
    clear_ops();
    for (int f = 0; f < 2; f++) begin
      // Half an ulp of 1.0, then three quarters
      tie      = (f == 0);
      fraction = tie ? 32'h33800000 : 32'h33c00000;
      for (int s = 0; s < 2; s++) begin
        neg = (s == 1);
        for (int m = 0; m < 5; m++) begin
          queue_op({neg, ONE[30:0]}, ONE, {neg, fraction[30:0]}, FMADD, 1'b0, modes[m],
                   {neg, ONE[30:0] + 31'(rounds_away(modes[m], neg, tie))}, NX_ONLY);
        end
      end
    end
    run_batch("rounding", 1'b0, 1'b0);
    end_test("rounding", errors_before);
  endtask

  task automatic overflow_cases();
    int errors_before;
    errors_before = errors;
    clear_ops();
    queue_op(MAX_NORMAL, to_single(2.0), ONE, MUL, 1'b0, RNE, POS_INF, OF_NX);
    queue_op(MAX_NORMAL, to_single(2.0), ONE, MUL, 1'b0, RTZ, MAX_NORMAL, OF_NX);
    run_batch("overflow", 1'b0, 1'b0);
    end_test("overflow", errors_before);
  endtask

  task automatic backpressure_stream();
    int   errors_before;
    real  a;
    real  b;
    real  c;
    logic mod;
    errors_before = errors;
    clear_ops();
    for (int i = 0; i < 12; i++) begin
      // Nonzero small integers keep every result exact
      a   = real'(($random(seed) & 7) + 1);
      b   = real'(($random(seed) & 7) + 1);
      c   = real'(($random(seed) & 31) + 1);
      mod = 1'($random(seed));
      if ($random(seed) & 1) begin
        a = -a;
      end
      queue_fused(a, b, c, FMADD, mod);
    end
    run_batch("backpressure", 1'b1, 1'b0);
    if (busy_o) begin
      report_error("busy_o still high after the pipeline drained");
    end
    end_test("backpressure", errors_before);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : main
    in_valid_i  = 1'b0;
    in_req_i    = '0;
    out_ready_i = 1'b1;
    @(posedge arst_n);
    fused_ops();
    add_sub_mul();
    special_cases();
    rounding_modes();
    overflow_cases();
    backpressure_stream();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* bench/fma_clock_gen.sv */
// Clock of period 10 starting low. Reset is held low for 5 cycles and released on a falling edge
module fma_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // Free-running clock
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // Reset released away from the active edge
  initial begin
    arst_n_o = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

/* hdl/fma_top.sv */
// Fixed three-stage FMA for binary32. No flush, so items in flight always complete in order
`include "fma_consts.svh"

module fma_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  fma_pkg::fma_req_t  in_req_i,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output fma_pkg::fma_resp_t out_resp_o,
  output logic               busy_o
);
  import fma_pkg::*;

  fma_req_t  req_q;
  wire fma_mid_t mid_d;
  fma_mid_t  mid_q;
  fma_resp_t resp_d;
  logic      req_valid, mid_valid;
  logic      mid_ready, out_ready;
  fp_t       op_a, op_b, op_c;
  fp_info_t  info_a, info_b, info_c;
  exp_int_t  final_exp;
  logic [`FMA_PREC:0] final_mant;
  logic      sticky;

  // --------------------------------------------------
  // Input stage
  // --------------------------------------------------
  fma_pipe_stage #(.payload_t(fma_req_t)) u_in_stage (
    .clk_i, .arst_n_i,
    .valid_i (in_valid_i), .data_i (in_req_i), .ready_o (in_ready_o),
    .valid_o (req_valid),  .data_o (req_q),    .ready_i (mid_ready)
  );

  fma_operand_prep u_prep (
    .req_i (req_q),
    .op_a_o (op_a), .op_b_o (op_b), .op_c_o (op_c),
    .info_a_o (info_a), .info_b_o (info_b), .info_c_o (info_c),
    .is_special_o (mid_d.is_special), .special_result_o (mid_d.special_result),
    .special_status_o (mid_d.special_status)
  );

  fma_mant_datapath u_datapath (
    .op_a_i (op_a), .op_b_i (op_b), .op_c_i (op_c),
    .info_a_i (info_a), .info_b_i (info_b), .info_c_i (info_c),
    .eff_sub_o (mid_d.eff_sub), .exp_prod_o (mid_d.exp_prod),
    .exp_diff_o (mid_d.exp_diff), .tent_exp_o (mid_d.tent_exp),
    .addend_shamt_o (mid_d.addend_shamt), .sticky_before_add_o (mid_d.sticky_before_add),
    .sum_o (mid_d.sum), .final_sign_o (mid_d.final_sign)
  );

  // Rounding mode rides along to the back half
  assign mid_d.rnd_mode = req_q.rnd_mode;

  // --------------------------------------------------
  // Middle and output stages
  // --------------------------------------------------
  fma_pipe_stage #(.payload_t(fma_mid_t)) u_mid_stage (
    .clk_i, .arst_n_i,
    .valid_i (req_valid), .data_i (mid_d), .ready_o (mid_ready),
    .valid_o (mid_valid), .data_o (mid_q), .ready_i (out_ready)
  );

  fma_normalize u_norm (
    .sum_i (mid_q.sum), .exp_prod_i (mid_q.exp_prod), .exp_diff_i (mid_q.exp_diff),
    .tent_exp_i (mid_q.tent_exp), .addend_shamt_i (mid_q.addend_shamt),
    .eff_sub_i (mid_q.eff_sub), .sticky_before_add_i (mid_q.sticky_before_add),
    .final_exp_o (final_exp), .final_mant_o (final_mant), .sticky_o (sticky)
  );

  fma_round u_round (
    .final_exp_i (final_exp), .final_mant_i (final_mant), .sticky_i (sticky),
    .sign_i (mid_q.final_sign), .rnd_mode_i (mid_q.rnd_mode), .eff_sub_i (mid_q.eff_sub),
    .is_special_i (mid_q.is_special), .special_result_i (mid_q.special_result),
    .special_status_i (mid_q.special_status), .resp_o (resp_d)
  );

  fma_pipe_stage #(.payload_t(fma_resp_t)) u_out_stage (
    .clk_i, .arst_n_i,
    .valid_i (mid_valid),   .data_i (resp_d),     .ready_o (out_ready),
    .valid_o (out_valid_o), .data_o (out_resp_o), .ready_i (out_ready_i)
  );

  assign busy_o = req_valid | mid_valid | out_valid_o;

endmodule

/* hdl/fma_round.sv */
// RISC-V rounding with tininess detected after rounding. DZ is never raised by an FMA
`include "fma_consts.svh"

module fma_round (
  input  fma_pkg::exp_int_t   final_exp_i,
  input  logic [`FMA_PREC:0]  final_mant_i,
  input  logic                sticky_i,
  input  logic                sign_i,
  input  fma_pkg::roundmode_e rnd_mode_i,
  input  logic                eff_sub_i,
  input  logic                is_special_i,
  input  fma_pkg::fp_t        special_result_i,
  input  fma_pkg::status_t    special_status_i,
  output fma_pkg::fma_resp_t  resp_o
);
  import fma_pkg::*;

  localparam int ABS_W = `FMA_EXP_BITS + `FMA_MAN_BITS;

  logic                     of_before, of_after, uf_after;
  logic [`FMA_EXP_BITS-1:0] pre_exp;
  logic [`FMA_MAN_BITS-1:0] pre_mant;
  logic [ABS_W-1:0]         pre_abs, abs_rounded;
  logic [1:0]               rs_bits;
  logic                     round_up, exact_zero, rounded_sign;
  status_t                  regular_status;

  // --------------------------------------------------
  // Pre-round assembly
  // --------------------------------------------------
  assign of_before = final_exp_i >= (2 ** `FMA_EXP_BITS) - 1;

  // Overflow becomes max normal plus round and sticky so the mode picks inf or max normal
  assign pre_exp  = of_before ? {{(`FMA_EXP_BITS-1){1'b1}}, 1'b0}
                              : final_exp_i[`FMA_EXP_BITS-1:0];
  assign pre_mant = of_before ? '1 : final_mant_i[`FMA_MAN_BITS:1];
  assign pre_abs  = {pre_exp, pre_mant};
  assign rs_bits  = of_before ? 2'b11 : {final_mant_i[0], sticky_i};

  always_comb begin : round_decision
    case (rnd_mode_i)
      // Tie goes to even
      RNE:     round_up = rs_bits[1] & (rs_bits[0] | pre_abs[0]);
      RTZ:     round_up = 1'b0;
      RDN:     round_up = (|rs_bits) & sign_i;
      RUP:     round_up = (|rs_bits) & ~sign_i;
      // Tie goes away from zero
      RMM:     round_up = rs_bits[1];
      default: round_up = 1'b0;
    endcase
  end

  // Mantissa carry ripples into the exponent
  assign abs_rounded = pre_abs + ABS_W'(round_up);

  // x - x gives +0, except -0 under RDN
  assign exact_zero   = (pre_abs == '0) && (rs_bits == 2'b00);
  assign rounded_sign = (exact_zero && eff_sub_i) ? (rnd_mode_i == RDN) : sign_i;

  // --------------------------------------------------
  // Flags and result selection
  // --------------------------------------------------
  assign uf_after = abs_rounded[ABS_W-1 -: `FMA_EXP_BITS] == '0;
  assign of_after = abs_rounded[ABS_W-1 -: `FMA_EXP_BITS] == '1;

  assign regular_status.nv = 1'b0;
  assign regular_status.of = of_before | of_after;
  assign regular_status.nx = (|rs_bits) | of_before | of_after;
  // Only an inexact tiny result underflows
  assign regular_status.uf = uf_after & regular_status.nx;

  assign resp_o.result = is_special_i ? fp_word_t'(special_result_i)
                                      : {rounded_sign, abs_rounded};
  assign resp_o.status = is_special_i ? special_status_i : regular_status;

endmodule

/* hdl/fma_normalize.sv */
// Left-normalizes the sum. Bit 0 of the mantissa output is the round bit, not a mantissa bit
`include "fma_consts.svh"

module fma_normalize (
  input  fma_pkg::sum_t      sum_i,
  input  fma_pkg::exp_int_t  exp_prod_i,
  input  fma_pkg::exp_int_t  exp_diff_i,
  input  fma_pkg::exp_int_t  tent_exp_i,
  input  fma_pkg::shamt_t    addend_shamt_i,
  input  logic               eff_sub_i,
  input  logic               sticky_before_add_i,
  output fma_pkg::exp_int_t  final_exp_o,
  output logic [`FMA_PREC:0] final_mant_o,
  output logic               sticky_o
);
  import fma_pkg::*;

  localparam int PREC    = `FMA_PREC;
  localparam int SUM_W   = `FMA_SUM_W;
  localparam int LOWER_W = `FMA_LOWER_W;
  localparam int LZC_W   = `FMA_LZC_W;

  logic [LOWER_W-1:0] sum_lower;
  logic [LZC_W-1:0]   lz_count;
  logic               lzc_zeroes;
  exp_int_t           lz_signed;
  shamt_t             norm_shamt;
  exp_int_t           norm_exp;
  logic [SUM_W:0]     sum_shifted;
  sum_t               aligned;

  // --------------------------------------------------
  // Leading zero count
  // --------------------------------------------------
  assign sum_lower = sum_i[LOWER_W-1:0];

  // The highest set bit overrides lower ones
  always_comb begin : lzc
    lz_count = '0;
    for (int i = 0; i < LOWER_W; i++) begin
      if (sum_lower[i]) begin
        lz_count = LZC_W'(LOWER_W - 1 - i);
      end
    end
  end

  assign lzc_zeroes = ~(|sum_lower);
  assign lz_signed  = exp_int_t'(lz_count);

  // --------------------------------------------------
  // Shift selection
  // --------------------------------------------------
  always_comb begin : norm_shift
    // Product anchored, or close cancellation
    if ((exp_diff_i <= 0) || (eff_sub_i && (exp_diff_i <= 2))) begin
      if ((exp_prod_i - lz_signed + 1 >= 0) && !lzc_zeroes) begin
        norm_shamt = shamt_t'(PREC + 2 + lz_count);
        norm_exp   = exp_prod_i - lz_signed + 1;
      end else begin
        // Stop at the minimum exponent and leave a subnormal
        norm_shamt = shamt_t'(PREC + 2 + exp_prod_i);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored, undo the alignment
      norm_shamt = addend_shamt_i;
      norm_exp   = tent_exp_i;
    end
  end

  assign sum_shifted = {1'b0, sum_i} << norm_shamt;

  // One-bit fix, the leading one may sit either side of the MSB
  always_comb begin : small_norm
    aligned     = sum_shifted[SUM_W-1:0];
    final_exp_o = norm_exp;
    if (sum_shifted[SUM_W]) begin
      aligned     = sum_shifted[SUM_W:1];
      final_exp_o = norm_exp + 1;
    end else if (!sum_shifted[SUM_W-1]) begin
      if (norm_exp > 1) begin
        aligned     = {sum_shifted[SUM_W-2:0], 1'b0};
        final_exp_o = norm_exp - 1;
      end else begin
        final_exp_o = '0;
      end
    end
  end

  assign final_mant_o = aligned[SUM_W-1 -: PREC+1];
  assign sticky_o     = (|aligned[LOWER_W-1:0]) | sticky_before_add_i;

endmodule

/* hdl/fma_mant_datapath.sv */
// Exponents stay biased internally. Results are meaningless for items flagged as special
`include "fma_consts.svh"

module fma_mant_datapath (
  input  fma_pkg::fp_t      op_a_i,
  input  fma_pkg::fp_t      op_b_i,
  input  fma_pkg::fp_t      op_c_i,
  input  fma_pkg::fp_info_t info_a_i,
  input  fma_pkg::fp_info_t info_b_i,
  input  fma_pkg::fp_info_t info_c_i,
  output logic              eff_sub_o,
  output fma_pkg::exp_int_t exp_prod_o,
  output fma_pkg::exp_int_t exp_diff_o,
  output fma_pkg::exp_int_t tent_exp_o,
  output fma_pkg::shamt_t   addend_shamt_o,
  output logic              sticky_before_add_o,
  output fma_pkg::sum_t     sum_o,
  output logic              final_sign_o
);
  import fma_pkg::*;

  localparam int PREC  = `FMA_PREC;
  localparam int SUM_W = `FMA_SUM_W;

  exp_int_t              exp_a, exp_b, exp_c, exp_addend;
  logic                  tent_sign;
  logic [PREC-1:0]       mant_a, mant_b, mant_c;
  logic [2*PREC-1:0]     product;
  sum_t                  product_shifted;
  logic [SUM_W+PREC-1:0] addend_wide;
  sum_t                  addend_aligned;
  sum_t                  addend_final;
  logic                  carry_in;
  logic [SUM_W:0]        sum_raw;
  logic                  sum_carry;

  // --------------------------------------------------
  // Exponent path
  // --------------------------------------------------
  assign exp_a = exp_int_t'(op_a_i.exponent);
  assign exp_b = exp_int_t'(op_b_i.exponent);
  assign exp_c = exp_int_t'(op_c_i.exponent);

  // Subnormals and zero sit at encoded exponent 1
  assign exp_addend = exp_c + exp_int_t'(!info_c_i.is_normal);
  // A zero product is parked at the lowest exponent
  assign exp_prod_o = (info_a_i.is_zero || info_b_i.is_zero)
                    ? exp_int_t'(2 - `FMA_BIAS)
                    : exp_a + exp_int_t'(info_a_i.is_subnormal)
                      + exp_b + exp_int_t'(info_b_i.is_subnormal) - exp_int_t'(`FMA_BIAS);
  assign exp_diff_o = exp_addend - exp_prod_o;
  assign tent_exp_o = (exp_diff_o > 0) ? exp_addend : exp_prod_o;

  // Right shift of the addend, saturated on both sides
  always_comb begin : addend_shift
    if (exp_diff_o <= -2 * PREC - 1) begin
      // Addend lands fully in the sticky bit
      addend_shamt_o = shamt_t'(3 * PREC + 4);
    end else if (exp_diff_o <= PREC + 2) begin
      addend_shamt_o = shamt_t'(PREC + 3 - exp_diff_o);
    end else begin
      // Product lands below the addend
      addend_shamt_o = '0;
    end
  end

  // --------------------------------------------------
  // Product and addend
  // --------------------------------------------------
  assign mant_a = {info_a_i.is_normal, op_a_i.mantissa};
  assign mant_b = {info_b_i.is_normal, op_b_i.mantissa};
  assign mant_c = {info_c_i.is_normal, op_c_i.mantissa};

  assign product = mant_a * mant_b;
  // Leave two bits below the product for round and sticky
  assign product_shifted = sum_t'(product) << 2;

  // Addend starts above the sum and up to p bits fall out as sticky
  assign addend_wide         = {mant_c, {SUM_W{1'b0}}} >> addend_shamt_o;
  assign addend_aligned      = addend_wide[SUM_W+PREC-1:PREC];
  assign sticky_before_add_o = |addend_wide[PREC-1:0];

  assign eff_sub_o = op_a_i.sign ^ op_b_i.sign ^ op_c_i.sign;
  assign tent_sign = op_a_i.sign ^ op_b_i.sign;

  // Ones complement for subtraction, the +1 is dropped when sticky bits were lost
  assign addend_final = eff_sub_o ? ~addend_aligned : addend_aligned;
  assign carry_in     = eff_sub_o & ~sticky_before_add_o;

  // --------------------------------------------------
  // Adder
  // --------------------------------------------------
  assign sum_raw   = product_shifted + addend_final + carry_in;
  assign sum_carry = sum_raw[SUM_W];

  // No carry in a subtraction means the addend won and the sum is negative
  assign sum_o        = (eff_sub_o && !sum_carry) ? sum_t'(-sum_raw) : sum_raw[SUM_W-1:0];
  assign final_sign_o = eff_sub_o ? (sum_carry == tent_sign) : tent_sign;

endmodule

/* hdl/fma_operand_prep.sv */
// Raw binary32 inputs without NaN-boxing. Any NaN result is the canonical quiet NaN 0x7fc00000
`include "fma_consts.svh"

module fma_operand_prep (
  input  fma_pkg::fma_req_t req_i,
  output fma_pkg::fp_t      op_a_o,
  output fma_pkg::fp_t      op_b_o,
  output fma_pkg::fp_t      op_c_o,
  output fma_pkg::fp_info_t info_a_o,
  output fma_pkg::fp_info_t info_b_o,
  output fma_pkg::fp_info_t info_c_o,
  output logic              is_special_o,
  output fma_pkg::fp_t      special_result_o,
  output fma_pkg::status_t  special_status_o
);
  import fma_pkg::*;

  logic any_inf;
  logic any_nan;
  logic any_snan;
  logic prod_inf;
  logic eff_sub;

  // Classification from the raw encoding
  function automatic fp_info_t classify(input fp_t value);
    fp_info_t info;
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    exp_zero           = (value.exponent == '0);
    exp_ones           = (value.exponent == '1);
    man_zero           = (value.mantissa == '0);
    info.is_normal     = !exp_zero && !exp_ones;
    info.is_subnormal  = exp_zero && !man_zero;
    info.is_zero       = exp_zero && man_zero;
    info.is_inf        = exp_ones && man_zero;
    info.is_nan        = exp_ones && !man_zero;
    // Quiet bit is the mantissa MSB
    info.is_signalling = info.is_nan && !value.mantissa[`FMA_MAN_BITS-1];
    return info;
  endfunction

  // --------------------------------------------------
  // Operation adjustments
  // --------------------------------------------------
  always_comb begin : op_select
    op_a_o   = fp_t'(req_i.operand_a);
    op_b_o   = fp_t'(req_i.operand_b);
    op_c_o   = fp_t'(req_i.operand_c);
    info_a_o = classify(op_a_o);
    info_b_o = classify(op_b_o);
    info_c_o = classify(op_c_o);
    // Modifier always negates the addend
    op_c_o.sign = op_c_o.sign ^ req_i.op_mod;
    unique case (req_i.op)
      FMADD: begin
      end
      // Negated product
      FNMSUB: op_a_o.sign = ~op_a_o.sign;
      // Multiplicand becomes +1.0
      ADD: begin
        op_a_o   = '{sign: 1'b0, exponent: `FMA_BIAS, mantissa: '0};
        info_a_o = '{is_normal: 1'b1, default: 1'b0};
      end
      // Addend becomes -0, or +0 under RDN so that x*0 keeps its own sign
      MUL: begin
        op_c_o   = '{sign: (req_i.rnd_mode != RDN), exponent: '0, mantissa: '0};
        info_c_o = '{is_zero: 1'b1, default: 1'b0};
      end
    endcase
  end

  // --------------------------------------------------
  // Special cases
  // --------------------------------------------------
  assign any_inf  = info_a_o.is_inf | info_b_o.is_inf | info_c_o.is_inf;
  assign any_nan  = info_a_o.is_nan | info_b_o.is_nan | info_c_o.is_nan;
  assign any_snan = info_a_o.is_signalling | info_b_o.is_signalling | info_c_o.is_signalling;
  assign prod_inf = info_a_o.is_inf | info_b_o.is_inf;
  assign eff_sub  = op_a_o.sign ^ op_b_o.sign ^ op_c_o.sign;

  always_comb begin : special_cases
    // Canonical qNaN unless an infinity case overrides it
    special_result_o = '{sign: 1'b0, exponent: '1,
                         mantissa: {1'b1, {(`FMA_MAN_BITS-1){1'b0}}}};
    special_status_o = '0;
    is_special_o     = 1'b0;
    // inf * 0 is invalid even with a quiet NaN addend
    if ((info_a_o.is_inf && info_b_o.is_zero) || (info_a_o.is_zero && info_b_o.is_inf)) begin
      is_special_o        = 1'b1;
      special_status_o.nv = 1'b1;
    end else if (any_nan) begin
      is_special_o        = 1'b1;
      special_status_o.nv = any_snan;
    end else if (any_inf) begin
      is_special_o = 1'b1;
      // inf - inf
      if (prod_inf && info_c_o.is_inf && eff_sub) begin
        special_status_o.nv = 1'b1;
      end else if (prod_inf) begin
        special_result_o = '{sign: op_a_o.sign ^ op_b_o.sign, exponent: '1, mantissa: '0};
      end else begin
        special_result_o = '{sign: op_c_o.sign, exponent: '1, mantissa: '0};
      end
    end
  end

endmodule

/* hdl/fma_pipe_stage.sv */
// Single register slice. Ready is combinational from downstream, so long chains add ready depth
module fma_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     ready_o,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i
);

  logic     valid_q;
  payload_t data_q;

  // Accept when downstream takes our item or we only hold a bubble
  assign ready_o = ready_i | ~valid_q;

  // Valid follows the input whenever the slice advances
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves with a real item, bubbles leave it untouched
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

/* hdl/fma_pkg.sv */
// Types for the binary32 FMA. Widths follow fma_consts.svh, enum encodings follow RISC-V
`include "fma_consts.svh"

package fma_pkg;

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------
  typedef logic [`FMA_WIDTH-1:0]          fp_word_t;
  typedef logic signed [`FMA_EXP_W-1:0]   exp_int_t;
  typedef logic [`FMA_SHAMT_W-1:0]        shamt_t;
  typedef logic [`FMA_SUM_W-1:0]          sum_t;

  typedef struct packed {
    logic                     sign;
    logic [`FMA_EXP_BITS-1:0] exponent;
    logic [`FMA_MAN_BITS-1:0] mantissa;
  } fp_t;

  // Same encoding as the frm field
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } roundmode_e;

  // op_mod selects the negated-addend variant
  typedef enum logic [1:0] {
    FMADD  = 2'd0,
    FNMSUB = 2'd1,
    ADD    = 2'd2,
    MUL    = 2'd3
  } operation_e;

  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // fflags order without DZ
  typedef struct packed {
    logic nv;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // --------------------------------------------------
  // Stage payloads
  // --------------------------------------------------
  typedef struct packed {
    fp_word_t   operand_a;
    fp_word_t   operand_b;
    fp_word_t   operand_c;
    roundmode_e rnd_mode;
    operation_e op;
    logic       op_mod;
  } fma_req_t;

  typedef struct packed {
    logic       eff_sub;
    exp_int_t   exp_prod;
    exp_int_t   exp_diff;
    exp_int_t   tent_exp;
    shamt_t     addend_shamt;
    logic       sticky_before_add;
    sum_t       sum;
    logic       final_sign;
    roundmode_e rnd_mode;
    logic       is_special;
    fp_t        special_result;
    status_t    special_status;
  } fma_mid_t;

  typedef struct packed {
    fp_word_t result;
    status_t  status;
  } fma_resp_t;

endpackage

/* include/fma_consts.svh */
// binary32 only. All internal widths derive from the field widths and must not be edited apart
`ifndef FMA_CONSTS_SVH
`define FMA_CONSTS_SVH

// --------------------------------------------------
// binary32 encoding
// --------------------------------------------------
`define FMA_EXP_BITS 8
`define FMA_MAN_BITS 23
`define FMA_WIDTH    (`FMA_EXP_BITS + `FMA_MAN_BITS + 1)
`define FMA_BIAS     127

// --------------------------------------------------
// Internal datapath widths
// --------------------------------------------------
// Precision p with the hidden bit
`define FMA_PREC    (`FMA_MAN_BITS + 1)
// Product, addend and the two guard bits side by side
`define FMA_SUM_W   (3 * `FMA_PREC + 4)
// Lower part of the sum searched for the leading one
`define FMA_LOWER_W (2 * `FMA_PREC + 3)
`define FMA_LZC_W   $clog2(`FMA_LOWER_W)
// Signed exponent with room for overflow and underflow
`define FMA_EXP_W   (`FMA_EXP_BITS + 2)
`define FMA_SHAMT_W $clog2(3 * `FMA_PREC + 5)

`endif
